// File: Bender.yml
package:
  name: mem_stage

sources:
  # design
  - files:
      - rtl/dcif_pkg.sv
      - rtl/dcif_control_store.sv
      - rtl/dcif_microsequencer.sv
      - rtl/dcache_interface.sv
      - rtl/dcache_array.sv
      - rtl/mem_stage_top.sv

  # testbench, top module tb_mem_stage
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_mem_stage.sv

// File: rtl/dcache_array.sv
// tagless direct-mapped word array, index from address bits 10..3
// one read outstanding; response valid DP_LATENCY cycles after accept
// a fill in the same cycle blocks the request
`timescale 1ns/100ps
`default_nettype none

module dcache_array (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            fill_valid,
    input  dcif_pkg::addr_t fill_address,
    input  dcif_pkg::data_t fill_data,
    input  logic            rd_req_valid,
    output logic            rd_req_ready,
    input  dcif_pkg::addr_t rd_req_address,
    output logic            rd_dp_valid,
    input  logic            rd_dp_ready,
    output dcif_pkg::data_t rd_dp_read_data
);
    import dcif_pkg::*;

    data_t                mem [DCACHE_WORDS];
    data_t                resp_data;
    idx_t                 fill_idx;
    idx_t                 req_idx;
    logic                 pending;
    logic [DP_CNT_W-1:0]  cnt;
    logic                 req_accept;
    logic                 dp_take;

    // low 3 bits select a byte, dropped here
    assign fill_idx = fill_address[DCACHE_IDX_LSB +: DCACHE_IDX_W];
    assign req_idx  = rd_req_address[DCACHE_IDX_LSB +: DCACHE_IDX_W];

    // busy while a response is held or a fill writes
    assign rd_req_ready = ~pending & ~fill_valid;

    assign req_accept = rd_req_valid & rd_req_ready;
    assign dp_take    = rd_dp_valid & rd_dp_ready;

    // fill port, written on the edge
    always_ff @(posedge clk) begin
        if (fill_valid) begin
            mem[fill_idx] <= fill_data;
        end
    end

    // capture the word as it stands at acceptance
    always_ff @(posedge clk) begin
        if (req_accept) begin
            resp_data <= mem[req_idx];
        end
    end

    // latency countdown
    // valid is held until the interface takes it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
            cnt     <= '0;
        end else if (req_accept) begin
            pending <= 1'b1;
            cnt     <= DP_CNT_W'(DP_LATENCY - 1);
        end else if (dp_take) begin
            pending <= 1'b0;
        end else if (pending && cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign rd_dp_valid     = pending & (cnt == '0);
    assign rd_dp_read_data = resp_data;

endmodule

`default_nettype wire

// File: rtl/dcache_interface.sv
// microcoded read interface, one cache read per accepted instruction
// op1 wins over op0; both invalid means no transfer at all
// downstream must take data_out in its single e_valid cycle
`timescale 1ns/100ps
`default_nettype none

module dcache_interface (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            a_valid,
    input  logic            e_ready,
    input  dcif_pkg::addr_t op0_address,
    input  logic            op0_address_is_valid,
    input  dcif_pkg::addr_t op1_address,
    input  logic            op1_address_is_valid,
    output logic            a_ready,
    output logic            e_valid,
    output dcif_pkg::data_t data_out,
    output logic            rd_req_valid,
    input  logic            rd_req_ready,
    output dcif_pkg::addr_t rd_req_address,
    input  logic            rd_dp_valid,
    output logic            rd_dp_ready,
    input  dcif_pkg::data_t rd_dp_read_data
);
    import dcif_pkg::*;

    ustate_e    ustate;
    uword_t     uword;
    ucond_e     cond;
    logic [2:0] jump;
    logic       ld_mdr;
    logic       op_accept;
    addr_t      op_sel;
    addr_t      addr_q;

    dcif_control_store u_control_store (
        .ustate (ustate),
        .uword  (uword)
    );

    dcif_microsequencer u_microsequencer (
        .clk                  (clk),
        .rst_n                (rst_n),
        .jump                 (jump),
        .cond                 (cond),
        .a_valid              (a_valid),
        .e_ready              (e_ready),
        .op0_address_is_valid (op0_address_is_valid),
        .op1_address_is_valid (op1_address_is_valid),
        .rd_req_ready         (rd_req_ready),
        .rd_dp_valid          (rd_dp_valid),
        .ustate               (ustate)
    );

    // microword decode
    assign e_valid      = uword[UW_E_VALID];
    assign a_ready      = uword[UW_A_READY];
    assign cond         = ucond_e'(uword[UW_COND_LSB +: 2]);
    assign jump         = uword[UW_JUMP_LSB +: 3];
    assign rd_req_valid = uword[UW_RD_REQ_VALID];
    assign rd_dp_ready  = uword[UW_RD_DP_READY];
    assign ld_mdr       = uword[UW_LD_MDR];

    // a_ready is only set in idle so this is the start cycle
    assign op_accept = a_valid & a_ready & e_ready
                     & (op0_address_is_valid | op1_address_is_valid);

    // reference mux priority
    assign op_sel = op1_address_is_valid ? op1_address : op0_address;

    // upstream may move on after the start cycle
    always_ff @(posedge clk) begin
        if (op_accept) begin
            addr_q <= op_sel;
        end
    end

    assign rd_req_address = addr_q;

    // mdr holds until the next response transfer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_out <= '0;
        end else if (ld_mdr && rd_dp_valid && rd_dp_ready) begin
            data_out <= rd_dp_read_data;
        end
    end

endmodule

`default_nettype wire

// File: rtl/dcif_control_store.sv
// microcode table for the dcache read interface
// purely combinational; unknown states fall back to idle with strobes off
`timescale 1ns/100ps
`default_nettype none

module dcif_control_store (
    input  dcif_pkg::ustate_e ustate,
    output dcif_pkg::uword_t  uword
);
    import dcif_pkg::*;

    // field order matches the UW_* positions in the package
    function automatic uword_t pack_uword(
        input logic    e_valid,
        input logic    a_ready,
        input ucond_e  cond,
        input ustate_e jump,
        input logic    req_valid,
        input logic    dp_ready,
        input logic    ld_mdr
    );
        return {e_valid, a_ready, cond, jump, req_valid, dp_ready, ld_mdr};
    endfunction

    always_comb begin
        case (ustate)
            // wait for an operand, start lifts jump to US_REQ
            US_IDLE: begin
                uword = pack_uword(1'b0, 1'b1, UC_START, US_IDLE, 1'b0, 1'b0, 1'b0);
            end
            // hold request until the array takes it
            US_REQ: begin
                uword = pack_uword(1'b0, 1'b0, UC_REQ_READY, US_REQ, 1'b1, 1'b0, 1'b0);
            end
            // accept response and load mdr
            US_WAIT: begin
                uword = pack_uword(1'b0, 1'b0, UC_DP_VALID, US_WAIT, 1'b0, 1'b1, 1'b1);
            end
            // result valid for exactly one cycle
            US_DONE: begin
                uword = pack_uword(1'b1, 1'b0, UC_NONE, US_IDLE, 1'b0, 1'b0, 1'b0);
            end
            default: begin
                uword = pack_uword(1'b0, 1'b0, UC_NONE, US_IDLE, 1'b0, 1'b0, 1'b0);
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/dcif_microsequencer.sv
// next microstate = jump target ORed with the selected condition bit
// start is only sampled through UC_START so it matters in idle alone
`timescale 1ns/100ps
`default_nettype none

module dcif_microsequencer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [2:0]        jump,
    input  dcif_pkg::ucond_e  cond,
    input  logic              a_valid,
    input  logic              e_ready,
    input  logic              op0_address_is_valid,
    input  logic              op1_address_is_valid,
    input  logic              rd_req_ready,
    input  logic              rd_dp_valid,
    output dcif_pkg::ustate_e ustate
);
    import dcif_pkg::*;

    logic       start;
    logic       start_hit;
    logic       req_hit;
    logic       dp_hit;
    logic [2:0] next_bits;

    // operand offered, downstream can take a result, some address valid
    assign start = a_valid & e_ready & (op0_address_is_valid | op1_address_is_valid);

    // one condition per microword
    assign start_hit = (cond == UC_START) & start;
    assign req_hit   = (cond == UC_REQ_READY) & rd_req_ready;
    assign dp_hit    = (cond == UC_DP_VALID) & rd_dp_valid;

    // each condition owns one bit of the target
    assign next_bits = jump | {req_hit, start_hit, dp_hit};

    // microstate register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ustate <= US_IDLE;
        end else begin
            ustate <= ustate_e'(next_bits);
        end
    end

endmodule

`default_nettype wire

// File: rtl/dcif_pkg.sv
// shared types and constants for the memory-operand stage
// array is direct mapped with no tags and ignores the low 3 address bits
// microstate encodings are fixed because condition bits are ORed into jump
`default_nettype none

package dcif_pkg;

    // datapath widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;
    localparam int UW_W   = 10;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [UW_W-1:0]   uword_t;

    // bit 1 set by start, bit 2 by request ready, bit 0 by response valid
    typedef enum logic [2:0] {
        US_IDLE = 3'b000,
        US_REQ  = 3'b010,
        US_WAIT = 3'b110,
        US_DONE = 3'b111
    } ustate_e;

    typedef enum logic [1:0] {
        UC_NONE      = 2'b00,
        UC_START     = 2'b01,
        UC_REQ_READY = 2'b10,
        UC_DP_VALID  = 2'b11
    } ucond_e;

    // microword field positions
    localparam int UW_E_VALID      = 9;
    localparam int UW_A_READY      = 8;
    localparam int UW_COND_LSB     = 6;
    localparam int UW_JUMP_LSB     = 3;
    localparam int UW_RD_REQ_VALID = 2;
    localparam int UW_RD_DP_READY  = 1;
    localparam int UW_LD_MDR       = 0;

    // data array geometry
    localparam int DCACHE_WORDS   = 256;
    localparam int DCACHE_IDX_W   = 8;
    localparam int DCACHE_IDX_LSB = 3;

    typedef logic [DCACHE_IDX_W-1:0] idx_t;

    // request accept to response valid
    localparam int DP_LATENCY = 2;
    localparam int DP_CNT_W   = $clog2(DP_LATENCY + 1);

endpackage

`default_nettype wire

// File: rtl/mem_stage_top.sv
// memory-operand stage: read interface plus its data array
// fills come straight from the environment, no ready on that port
`timescale 1ns/100ps
`default_nettype none

module mem_stage_top (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            a_valid,
    input  logic            e_ready,
    input  dcif_pkg::addr_t op0_address,
    input  logic            op0_address_is_valid,
    input  dcif_pkg::addr_t op1_address,
    input  logic            op1_address_is_valid,
    output logic            a_ready,
    output logic            e_valid,
    output dcif_pkg::data_t data_out,
    input  logic            fill_valid,
    input  dcif_pkg::addr_t fill_address,
    input  dcif_pkg::data_t fill_data
);
    import dcif_pkg::*;

    // request channel
    logic  rd_req_valid;
    logic  rd_req_ready;
    addr_t rd_req_address;
    // response channel
    logic  rd_dp_valid;
    logic  rd_dp_ready;
    data_t rd_dp_read_data;

    dcache_interface u_dcache_interface (
        .clk                  (clk),
        .rst_n                (rst_n),
        .a_valid              (a_valid),
        .e_ready              (e_ready),
        .op0_address          (op0_address),
        .op0_address_is_valid (op0_address_is_valid),
        .op1_address          (op1_address),
        .op1_address_is_valid (op1_address_is_valid),
        .a_ready              (a_ready),
        .e_valid              (e_valid),
        .data_out             (data_out),
        .rd_req_valid         (rd_req_valid),
        .rd_req_ready         (rd_req_ready),
        .rd_req_address       (rd_req_address),
        .rd_dp_valid          (rd_dp_valid),
        .rd_dp_ready          (rd_dp_ready),
        .rd_dp_read_data      (rd_dp_read_data)
    );

    dcache_array u_dcache_array (
        .clk             (clk),
        .rst_n           (rst_n),
        .fill_valid      (fill_valid),
        .fill_address    (fill_address),
        .fill_data       (fill_data),
        .rd_req_valid    (rd_req_valid),
        .rd_req_ready    (rd_req_ready),
        .rd_req_address  (rd_req_address),
        .rd_dp_valid     (rd_dp_valid),
        .rd_dp_ready     (rd_dp_ready),
        .rd_dp_read_data (rd_dp_read_data)
    );

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
// free-running clock and synchronous reset for the testbench
// reset drops a short delay after the last reset edge
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // held low over RESET_CYCLES rising edges
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: sim/tb_mem_stage.sv
// random offers and fills from a fixed seed, checked against a cycle model
// inputs change 2 ns after the rising edge, outputs sampled on the falling edge
// the model knows only the stage timing and its own copy of the array
`timescale 1ns/100ps
`default_nettype none

module tb_mem_stage;
    import dcif_pkg::*;

    localparam int          CLK_PERIOD_NS   = 40;
    localparam int          DRIVE_DELAY     = 2;
    localparam int          N_INSTR         = 300;
    localparam int          WATCHDOG_CYCLES = N_INSTR * 12 + DCACHE_WORDS + 100;
    localparam logic [31:0] SEED            = 32'hff67_70b6;

    // model phases
    localparam int PH_IDLE = 0;
    localparam int PH_REQ  = 1;
    localparam int PH_RESP = 2;

    logic  clk;
    logic  rst_n;
    logic  a_valid;
    logic  e_ready;
    addr_t op0_address;
    logic  op0_address_is_valid;
    addr_t op1_address;
    logic  op1_address_is_valid;
    logic  a_ready;
    logic  e_valid;
    data_t data_out;
    logic  fill_valid;
    addr_t fill_address;
    data_t fill_data;

    // reference model state
    data_t model_mem [DCACHE_WORDS];
    int    ph          = PH_IDLE;
    int    start_cycle = 0;
    int    blocked     = 0;
    int    cycle       = 0;
    addr_t exp_addr;
    data_t exp_word;
    data_t last_data   = '0;
    idx_t  hit_idx;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD_NS),
        .RESET_CYCLES (5)
    ) u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mem_stage_top dut0 (
        .clk                  (clk),
        .rst_n                (rst_n),
        .a_valid              (a_valid),
        .e_ready              (e_ready),
        .op0_address          (op0_address),
        .op0_address_is_valid (op0_address_is_valid),
        .op1_address          (op1_address),
        .op1_address_is_valid (op1_address_is_valid),
        .a_ready              (a_ready),
        .e_valid              (e_valid),
        .data_out             (data_out),
        .fill_valid           (fill_valid),
        .fill_address         (fill_address),
        .fill_data            (fill_data)
    );

    // word index is byte address bits 10..3
    function automatic idx_t index_of(input addr_t a);
        return a[10:3];
    endfunction

    function automatic logic chance(input int pct);
        return $urandom_range(99) < pct;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h (cycle %0d)",
                                name, got, exp, cycle));
        end
    endtask

    task automatic check_data(input data_t got, input data_t exp, input string name);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h (cycle %0d)",
                                name, got, exp, cycle));
        end
    endtask

    task automatic step();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // half the fills land on the word in flight
    task automatic maybe_fill(input idx_t target, input int pct);
        fill_valid   = chance(pct);
        fill_data    = {$urandom(), $urandom()};
        fill_address = $urandom();
        if (chance(50)) begin
            fill_address[10:3] = target;
        end
    endtask

    // idle gap, no offer
    task automatic drive_gap();
        a_valid              = 1'b0;
        e_ready              = chance(50);
        op0_address          = $urandom();
        op1_address          = $urandom();
        op0_address_is_valid = chance(50);
        op1_address_is_valid = chance(50);
        maybe_fill(hit_idx, 10);
    endtask

    // stage busy, upstream noise must be ignored
    task automatic drive_busy();
        a_valid              = chance(50);
        e_ready              = chance(70);
        op0_address          = $urandom();
        op1_address          = $urandom();
        op0_address_is_valid = chance(50);
        op1_address_is_valid = chance(50);
        maybe_fill(hit_idx, 30);
    endtask

    // includes both-invalid and e_ready low offers
    task automatic drive_offer();
        a_valid              = 1'b1;
        e_ready              = chance(80);
        op0_address          = $urandom();
        op1_address          = $urandom();
        op0_address_is_valid = chance(65);
        op1_address_is_valid = chance(50);
        hit_idx = op1_address_is_valid ? index_of(op1_address) : index_of(op0_address);
        maybe_fill(hit_idx, 30);
    endtask

    // stimulus
    initial begin
        a_valid              = 1'b0;
        e_ready              = 1'b0;
        op0_address          = '0;
        op0_address_is_valid = 1'b0;
        op1_address          = '0;
        op1_address_is_valid = 1'b0;
        fill_valid           = 1'b0;
        fill_address         = '0;
        fill_data            = '0;
        hit_idx              = '0;
        void'($urandom(SEED));
        wait (rst_n === 1'b1);
        // preload every word, upper address bits random
        for (int i = 0; i < DCACHE_WORDS; i++) begin
            step();
            fill_valid         = 1'b1;
            fill_address       = $urandom();
            fill_address[10:3] = idx_t'(i);
            fill_data          = {$urandom(), $urandom()};
        end
        for (int n = 0; n < N_INSTR; n++) begin
            repeat ($urandom_range(2)) begin
                step();
                drive_gap();
            end
            step();
            while (a_ready !== 1'b1) begin
                drive_busy();
                step();
            end
            drive_offer();
        end
        step();
        a_valid    = 1'b0;
        fill_valid = 1'b0;
        wait (ph == PH_IDLE);
        repeat (4) @(posedge clk);
        $display("Test completed successfully");
        $finish;
    end

    // cycle model, one pass per falling edge
    initial begin
        logic exp_ev;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge clk);
            cycle++;
            check_bit(a_ready, ph == PH_IDLE, "a_ready");
            // 4 cycles after start plus one per blocked request cycle
            exp_ev = (ph == PH_RESP) && (cycle == start_cycle + 4 + blocked);
            check_bit(e_valid, exp_ev, "e_valid");
            if (exp_ev) begin
                last_data = exp_word;
            end
            // mdr holds between results
            check_data(data_out, last_data, "data_out");
            case (ph)
                PH_IDLE: begin
                    if (a_valid && e_ready && (op0_address_is_valid || op1_address_is_valid)) begin
                        exp_addr    = op1_address_is_valid ? op1_address : op0_address;
                        start_cycle = cycle;
                        blocked     = 0;
                        ph          = PH_REQ;
                    end
                end
                // a fill in this cycle refuses the request
                PH_REQ: begin
                    if (fill_valid) begin
                        blocked++;
                    end else begin
                        exp_word = model_mem[index_of(exp_addr)];
                        ph       = PH_RESP;
                    end
                end
                default: begin
                    if (exp_ev) begin
                        ph = PH_IDLE;
                    end
                end
            endcase
            // fill lands on the closing edge
            if (fill_valid) begin
                model_mem[index_of(fill_address)] = fill_data;
            end
        end
    end

    // watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        abort_run("watchdog expired before all instructions finished");
    end

endmodule

`default_nettype wire

// File: tb.f
rtl/dcif_pkg.sv
rtl/dcif_control_store.sv
rtl/dcif_microsequencer.sv
rtl/dcache_interface.sv
rtl/dcache_array.sv
rtl/mem_stage_top.sv
sim/tb_clock_gen.sv
sim/tb_mem_stage.sv
